// ==== include/heap_defs.svh ====
// Width settings shared by the heap package and RTL modules.
// Include wherever an array number, index or element width is needed.

`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

//--------------------------------------------------
// Basic field widths
//--------------------------------------------------
`define HEAP_ARRAY_BITS 2                          // Four arrays
`define HEAP_INDEX_BITS 3                          // Eight elements each
`define HEAP_DATA_BITS  12                         // Element width

//--------------------------------------------------
// Derived counts
//--------------------------------------------------
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)        // Number of arrays
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)        // Elements per array

`endif

// ==== verilog/heapPkg.sv ====
// Types shared by the heap RTL and its testbench.
// Action codes are sparse, and a code not listed here is answered as a no-op.
`default_nettype none

`include "heap_defs.svh"

package heapPkg;

  //--------------------------------------------------
  // Request decoding
  //--------------------------------------------------
  typedef enum logic [4:0] {
    actReset    = 5'd1,                            // Clear all bookkeeping
    actWrite    = 5'd2,                            // Store an element
    actRead     = 5'd3,                            // Fetch an element
    actSize     = 5'd4,                            // Current array size
    actInc      = 5'd5,                            // Grow by one
    actDec      = 5'd6,                            // Shrink by one
    actPush     = 5'd14,                           // Append at the end
    actPop      = 5'd15,                           // Remove from the end
    actAlloc    = 5'd18,                           // Hand out an array
    actFree     = 5'd19,                           // Return an array
    actAdd      = 5'd20,                           // Add, report new value
    actAddAfter = 5'd21,                           // Add, report old value
    actSubtract = 5'd22,                           // Subtract, report new value
    actSubAfter = 5'd23,                           // Subtract, report old value
    actNot      = 5'd27,                           // Bitwise invert
    actOr       = 5'd28,
    actXor      = 5'd29,
    actAnd      = 5'd30
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                        // Above the high-water mark
    errFreed        = 3'd2,                        // Handed out once, now returned
    errOutOfBounds  = 3'd3,                        // Index at or past the size
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errOutOfMemory  = 3'd6                         // No array left to hand out
  } heapError_t;

  //--------------------------------------------------
  // Bundles between blocks
  //--------------------------------------------------
  typedef struct packed {
    heapAction_t                  action;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;
    logic [`HEAP_DATA_BITS-1:0]   data;
  } heapRequest_t;

  typedef struct packed {
    logic                         permit;          // Checks passed and strobed
    heapAction_t                  action;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  slot;            // Resolved element index
  } elementAccess_t;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0]   data;
    heapError_t                   error;
  } heapResponse_t;

endpackage

`default_nettype wire

// ==== verilog/arrayAllocator.sv ====
// Bookkeeping half of the heap: allocation flags, array sizes and free list.
// Checks every request combinationally and commits changes on the accepting edge.
`timescale 1ns/100ps
`default_nettype none

`include "heap_defs.svh"

module arrayAllocator (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        strobe,
  input  heapPkg::heapRequest_t       request,
  output heapPkg::elementAccess_t     access,
  output logic [`HEAP_DATA_BITS-1:0]  bookValue,
  output heapPkg::heapError_t         verdict
);

  localparam int Arrays = `HEAP_ARRAYS;

  logic                         allocated [Arrays];   // Array currently handed out
  logic [`HEAP_INDEX_BITS:0]    sizes     [Arrays];   // Elements in use per array
  logic [`HEAP_ARRAY_BITS-1:0]  freeStack [Arrays];   // Returned arrays, newest on top
  logic [`HEAP_ARRAY_BITS:0]    freeTop;              // Entries on the free stack
  logic [`HEAP_ARRAY_BITS:0]    highWater;            // Arrays ever handed out

  logic [`HEAP_INDEX_BITS:0]    size;                 // Size of the addressed array
  logic [`HEAP_ARRAY_BITS-1:0]  stackTop;             // Index of the newest free entry
  logic [`HEAP_ARRAY_BITS-1:0]  chosen;               // Array an Alloc would hand out
  logic                         fromFree;             // Alloc reuses a freed array
  logic [`HEAP_INDEX_BITS-1:0]  slot;
  logic                         permit;
  heapPkg::heapError_t          writeCheck;
  heapPkg::heapError_t          readCheck;

  //--------------------------------------------------
  // Access checks where a later failure overrides an earlier one
  //--------------------------------------------------
  always_comb begin : checks
    size       = sizes[request.array];
    writeCheck = heapPkg::errNone;
    if ({1'b0, request.array} >= highWater) begin
      writeCheck = heapPkg::errNotAllocated;          // Never handed out
    end
    if (!allocated[request.array] && {1'b0, request.array} < highWater) begin
      writeCheck = heapPkg::errFreed;                 // Returned to the free list
    end
    readCheck = writeCheck;
    if ({1'b0, request.index} >= size) begin
      readCheck = heapPkg::errOutOfBounds;
    end
  end

  // Freed arrays go out again before fresh ones
  assign fromFree = (freeTop != '0);
  assign stackTop = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign chosen   = fromFree ? freeStack[stackTop] : highWater[`HEAP_ARRAY_BITS-1:0];

  //--------------------------------------------------
  // Per-action verdict, slot and bookkeeping value
  //--------------------------------------------------
  always_comb begin : decide
    verdict   = heapPkg::errNone;
    slot      = request.index;
    bookValue = '0;
    case (request.action)
      heapPkg::actAlloc: begin
        if (!fromFree && highWater[`HEAP_ARRAY_BITS]) begin
          verdict = heapPkg::errOutOfMemory;          // Top bit set once all are out
        end
        bookValue[`HEAP_ARRAY_BITS-1:0] = chosen;
      end
      heapPkg::actWrite, heapPkg::actFree: verdict = writeCheck;
      heapPkg::actSize: begin
        verdict                         = writeCheck;
        bookValue[`HEAP_INDEX_BITS:0]   = size;
      end
      heapPkg::actInc, heapPkg::actPush: begin
        verdict = writeCheck;
        if (verdict == heapPkg::errNone && size[`HEAP_INDEX_BITS]) begin
          verdict = heapPkg::errFull;                 // Size already at the length
        end
        if (request.action == heapPkg::actPush) begin
          slot = size[`HEAP_INDEX_BITS-1:0];          // Append after the last element
        end
      end
      heapPkg::actDec, heapPkg::actPop: begin
        verdict = writeCheck;
        if (verdict == heapPkg::errNone && size == '0) begin
          verdict = heapPkg::errEmpty;
        end
        if (request.action == heapPkg::actPop) begin
          slot = size[`HEAP_INDEX_BITS-1:0] - 1'b1;   // Last element in use
        end
      end
      heapPkg::actRead, heapPkg::actAdd, heapPkg::actAddAfter,
      heapPkg::actSubtract, heapPkg::actSubAfter, heapPkg::actNot,
      heapPkg::actOr, heapPkg::actXor, heapPkg::actAnd: verdict = readCheck;
      default: verdict = heapPkg::errNone;            // Reset and unknown codes
    endcase
  end

  assign permit        = strobe && (verdict == heapPkg::errNone);
  assign access.permit = permit;
  assign access.action = request.action;
  assign access.array  = request.array;
  assign access.slot   = slot;

  //--------------------------------------------------
  // State updates on the accepting edge
  //--------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin : book
    if (!resetN) begin
      for (int i = 0; i < Arrays; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
      freeTop   <= '0;
      highWater <= '0;
    end else if (permit) begin
      case (request.action)
        heapPkg::actReset: begin                      // Back to the power-up state
          for (int i = 0; i < Arrays; i++) begin
            allocated[i] <= 1'b0;
            sizes[i]     <= '0;
          end
          freeTop   <= '0;
          highWater <= '0;
        end
        heapPkg::actAlloc: begin
          allocated[chosen] <= 1'b1;
          sizes[chosen]     <= '0;                    // New arrays start empty
          if (fromFree) freeTop <= freeTop - 1'b1;
          else highWater <= highWater + 1'b1;
        end
        heapPkg::actFree: begin
          allocated[request.array] <= 1'b0;
          freeTop                  <= freeTop + 1'b1;
        end
        heapPkg::actWrite: begin
          if ({1'b0, request.index} >= size) begin
            sizes[request.array] <= {1'b0, request.index} + 1'b1;   // Grow to cover index
          end
        end
        heapPkg::actInc, heapPkg::actPush: sizes[request.array] <= size + 1'b1;
        heapPkg::actDec, heapPkg::actPop:  sizes[request.array] <= size - 1'b1;
        default: ;                                    // Element-only actions
      endcase
    end
  end

  // Free stack payload is only meaningful below freeTop
  always_ff @(posedge clock) begin : stack
    if (permit && request.action == heapPkg::actFree) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= request.array;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/elementStore.sv ====
// Element half of the heap: one flat memory holding every array's elements.
// Reads and computes combinationally, writes on the accepting edge when permitted.
`timescale 1ns/100ps
`default_nettype none

`include "heap_defs.svh"

module elementStore (
  input  logic                        clock,
  input  heapPkg::elementAccess_t     access,
  input  logic [`HEAP_DATA_BITS-1:0]  data,
  output logic [`HEAP_DATA_BITS-1:0]  elementValue
);

  localparam int Words = `HEAP_ARRAYS * `HEAP_LENGTH;

  logic [`HEAP_DATA_BITS-1:0]                     memory [Words];  // Arrays in fixed blocks
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0]   address;         // Array number on top
  logic [`HEAP_DATA_BITS-1:0]                     oldValue;
  logic [`HEAP_DATA_BITS-1:0]                     newValue;
  logic                                           update;          // Action stores newValue

  assign address  = {access.array, access.slot};
  assign oldValue = memory[address];

  //--------------------------------------------------
  // Read-modify-write arithmetic
  //--------------------------------------------------
  always_comb begin : arithmetic
    newValue = data;                                  // Write and Push store input data
    update   = 1'b0;
    case (access.action)
      heapPkg::actWrite, heapPkg::actPush: update = 1'b1;
      heapPkg::actAdd, heapPkg::actAddAfter: begin
        newValue = oldValue + data;                   // Wraps at the data width
        update   = 1'b1;
      end
      heapPkg::actSubtract, heapPkg::actSubAfter: begin
        newValue = oldValue - data;
        update   = 1'b1;
      end
      heapPkg::actOr: begin
        newValue = oldValue | data;
        update   = 1'b1;
      end
      heapPkg::actXor: begin
        newValue = oldValue ^ data;
        update   = 1'b1;
      end
      heapPkg::actAnd: begin
        newValue = oldValue & data;
        update   = 1'b1;
      end
      heapPkg::actNot: begin
        newValue = ~oldValue;                         // Data input ignored
        update   = 1'b1;
      end
      default: update = 1'b0;
    endcase
  end

  // After-variants, Read and Pop report what was stored before
  always_comb begin : report
    case (access.action)
      heapPkg::actAddAfter, heapPkg::actSubAfter,
      heapPkg::actRead, heapPkg::actPop: elementValue = oldValue;
      default:                           elementValue = newValue;
    endcase
  end

  always_ff @(posedge clock) begin : store
    if (access.permit && update) begin
      memory[address] <= newValue;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/responseMerge.sv ====
// Output stage of the heap: picks bookkeeping or element data and registers it.
// Done follows every strobe by one cycle; data holds on errors and dataless actions.
`timescale 1ns/100ps
`default_nettype none

`include "heap_defs.svh"

module responseMerge (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        strobe,
  input  heapPkg::heapAction_t        action,
  input  heapPkg::heapError_t         verdict,
  input  logic [`HEAP_DATA_BITS-1:0]  bookValue,
  input  logic [`HEAP_DATA_BITS-1:0]  elementValue,
  output heapPkg::heapResponse_t      response,
  output logic                        done
);

  logic loadBook;                                     // Alloc and Size answer from bookkeeping
  logic loadElement;                                  // Element actions answer from the store

  always_comb begin : source
    loadBook    = 1'b0;
    loadElement = 1'b0;
    case (action)
      heapPkg::actAlloc, heapPkg::actSize: loadBook = 1'b1;
      heapPkg::actWrite, heapPkg::actRead, heapPkg::actPop,
      heapPkg::actAdd, heapPkg::actAddAfter, heapPkg::actSubtract,
      heapPkg::actSubAfter, heapPkg::actNot, heapPkg::actOr,
      heapPkg::actXor, heapPkg::actAnd: loadElement = 1'b1;
      default: ;                                      // Data register holds
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin : outputs
    if (!resetN) begin
      done           <= 1'b0;
      response.data  <= '0;
      response.error <= heapPkg::errNone;
    end else begin
      done <= strobe;                                 // Fixed one-cycle latency
      if (strobe) begin
        response.error <= verdict;
        if (verdict == heapPkg::errNone) begin
          if (loadBook) response.data <= bookValue;
          else if (loadElement) response.data <= elementValue;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/heapMemory.sv ====
// Heap of fixed-size arrays with a strobe-and-done request interface.
// One request per cycle, each answered with done and a response one cycle later.
`timescale 1ns/100ps
`default_nettype none

`include "heap_defs.svh"

module heapMemory (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    strobe,
  input  heapPkg::heapRequest_t   request,
  output heapPkg::heapResponse_t  response,
  output logic                    done
);

  heapPkg::elementAccess_t          access;           // Checked access to the store
  heapPkg::heapError_t              verdict;          // Check result for this request
  logic [`HEAP_DATA_BITS-1:0]       bookValue;        // Array number or size
  logic [`HEAP_DATA_BITS-1:0]       elementValue;     // Element result

  //--------------------------------------------------
  // Bookkeeping, storage and output register
  //--------------------------------------------------
  arrayAllocator i_allocator (
    .clock     (clock),
    .resetN    (resetN),
    .strobe    (strobe),
    .request   (request),
    .access    (access),
    .bookValue (bookValue),
    .verdict   (verdict)
  );

  elementStore i_store (
    .clock        (clock),
    .access       (access),
    .data         (request.data),
    .elementValue (elementValue)
  );

  responseMerge i_merge (
    .clock        (clock),
    .resetN       (resetN),
    .strobe       (strobe),
    .action       (request.action),
    .verdict      (verdict),
    .bookValue    (bookValue),
    .elementValue (elementValue),
    .response     (response),
    .done         (done)
  );

endmodule

`default_nettype wire

// ==== verification/heapMemory_assertions.sv ====
// Strobe and done protocol checks for the heap.
// Bound into every heapMemory instance, so no testbench wiring is needed.
`timescale 1ns/100ps
`default_nettype none

module heapMemory_assertions (
  input logic clock,
  input logic resetN,
  input logic strobe,
  input logic done
);

  //--------------------------------------------------
  // Done timing
  //--------------------------------------------------
  doneFollowsStrobe: assert property (
    @(posedge clock) disable iff (!resetN) strobe |=> done        // Fixed latency of one
  ) else $error("done missing one cycle after a strobe");

  doneNeedsStrobe: assert property (
    @(posedge clock) disable iff (!resetN) done |-> $past(strobe)
  ) else $error("done raised without a strobe one cycle before");

  // First edge out of reset
  doneLowAfterReset: assert property (
    @(posedge clock) $rose(resetN) |-> !done
  ) else $error("done high right after reset");

endmodule

bind heapMemory heapMemory_assertions i_assertions (
  .clock  (clock),
  .resetN (resetN),
  .strobe (strobe),
  .done   (done)
);

`default_nettype wire

// ==== verification/heapMemoryTb.sv ====
// Testbench for the heap: walks a table of requests through the DUT.
// Each row is strobed on a falling edge and its response checked one cycle later.
// Held rows expect the data register to keep the previous answer.
`timescale 1ns/100ps
`default_nettype none

`include "heap_defs.svh"

module heapMemoryTb;

  localparam int ClockPeriod = 40;
  localparam int ResetCycles = 3;

  typedef struct packed {
    heapPkg::heapAction_t          action;
    logic [`HEAP_ARRAY_BITS-1:0]   array;
    logic [`HEAP_INDEX_BITS-1:0]   index;
    logic [`HEAP_DATA_BITS-1:0]    data;
    logic                          hold;              // Data register must not change
    logic [`HEAP_DATA_BITS-1:0]    expData;
    heapPkg::heapError_t           expError;
  } tableRow_t;

  logic                          clock;
  logic                          resetN;
  logic                          strobe;
  heapPkg::heapRequest_t         request;
  heapPkg::heapResponse_t        response;
  logic                          done;

  tableRow_t                     steps [$];           // Stimulus table
  logic [`HEAP_DATA_BITS-1:0]    wantData [$];        // Holds resolved per row
  int                            errors;
  int                            checks;
  int                            cycles;
  int                            cycleLimit;

  heapMemory i_dut (
    .clock    (clock),
    .resetN   (resetN),
    .strobe   (strobe),
    .request  (request),
    .response (response),
    .done     (done)
  );

  initial begin : clockGen
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  // Stops a stuck run
  always @(posedge clock) begin : watchdog
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout: run still going after %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //--------------------------------------------------
  // Table building
  //--------------------------------------------------
  task automatic addRow(input heapPkg::heapAction_t action, input int array, input int index,
                        input int data, input int expData, input heapPkg::heapError_t expError);
    tableRow_t row;
    row.action   = action;
    row.array    = array[`HEAP_ARRAY_BITS-1:0];
    row.index    = index[`HEAP_INDEX_BITS-1:0];
    row.data     = data[`HEAP_DATA_BITS-1:0];
    row.hold     = 1'b0;
    row.expData  = expData[`HEAP_DATA_BITS-1:0];
    row.expError = expError;
    steps.push_back(row);
  endtask

  task automatic addHeldRow(input heapPkg::heapAction_t action, input int array,
                            input int index, input int data,
                            input heapPkg::heapError_t expError);
    addRow(action, array, index, data, 0, expError);
    steps[steps.size() - 1].hold = 1'b1;              // Expect previous data
  endtask

  task automatic buildTable();
    // Allocation order and free-list reuse
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 0, heapPkg::errNone);
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 1, heapPkg::errNone);
    addHeldRow(heapPkg::actFree, 0, 0, 'h000, heapPkg::errNone);
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 0, heapPkg::errNone);      // Array 0 again
    // Write, Size and Read
    addRow(heapPkg::actWrite, 0, 1, 'h123, 'h123, heapPkg::errNone);
    addRow(heapPkg::actWrite, 0, 2, 'h0AB, 'h0AB, heapPkg::errNone);
    addRow(heapPkg::actSize, 0, 0, 'h000, 3, heapPkg::errNone);
    addRow(heapPkg::actRead, 0, 1, 'h000, 'h123, heapPkg::errNone);
    addHeldRow(heapPkg::actRead, 0, 5, 'h000, heapPkg::errOutOfBounds);
    // Push, Pop, empty and full
    addHeldRow(heapPkg::actPush, 1, 0, 'h055, heapPkg::errNone);
    addRow(heapPkg::actPop, 1, 0, 'h000, 'h055, heapPkg::errNone);
    addRow(heapPkg::actSize, 1, 0, 'h000, 0, heapPkg::errNone);
    addHeldRow(heapPkg::actPop, 1, 0, 'h000, heapPkg::errEmpty);
    addRow(heapPkg::actWrite, 1, 7, 'h777, 'h777, heapPkg::errNone);  // Fills array 1
    addHeldRow(heapPkg::actPush, 1, 0, 'h111, heapPkg::errFull);
    addRow(heapPkg::actSize, 1, 0, 'h000, 8, heapPkg::errNone);
    // Read-modify-write chain on array 0 slot 2, starting at 0x0AB
    addRow(heapPkg::actAdd, 0, 2, 'hF60, 'h00B, heapPkg::errNone);    // 0x100B wraps
    addRow(heapPkg::actAddAfter, 0, 2, 'h010, 'h00B, heapPkg::errNone);
    addRow(heapPkg::actSubtract, 0, 2, 'h020, 'hFFB, heapPkg::errNone);
    addRow(heapPkg::actSubAfter, 0, 2, 'h0FF, 'hFFB, heapPkg::errNone);
    addRow(heapPkg::actOr, 0, 2, 'h003, 'hEFF, heapPkg::errNone);
    addRow(heapPkg::actXor, 0, 2, 'h0F0, 'hE0F, heapPkg::errNone);
    addRow(heapPkg::actAnd, 0, 2, 'h3C3, 'h203, heapPkg::errNone);
    addRow(heapPkg::actNot, 0, 2, 'h000, 'hDFC, heapPkg::errNone);
    addRow(heapPkg::actRead, 0, 2, 'h000, 'hDFC, heapPkg::errNone);
    // Freed and never allocated arrays
    addHeldRow(heapPkg::actFree, 1, 0, 'h000, heapPkg::errNone);
    addHeldRow(heapPkg::actRead, 1, 0, 'h000, heapPkg::errFreed);
    addHeldRow(heapPkg::actWrite, 3, 0, 'h005, heapPkg::errNotAllocated);
    addHeldRow(heapPkg::actSize, 2, 0, 'h000, heapPkg::errNotAllocated);
    // Exhaust the heap
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 1, heapPkg::errNone);      // Reused, starts empty
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 2, heapPkg::errNone);
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 3, heapPkg::errNone);
    addHeldRow(heapPkg::actAlloc, 0, 0, 'h000, heapPkg::errOutOfMemory);
    addRow(heapPkg::actSize, 1, 0, 'h000, 0, heapPkg::errNone);
    // Inc and Dec within bounds
    addHeldRow(heapPkg::actInc, 2, 0, 'h000, heapPkg::errNone);
    addHeldRow(heapPkg::actInc, 2, 0, 'h000, heapPkg::errNone);
    addRow(heapPkg::actSize, 2, 0, 'h000, 2, heapPkg::errNone);
    addHeldRow(heapPkg::actDec, 2, 0, 'h000, heapPkg::errNone);
    addRow(heapPkg::actSize, 2, 0, 'h000, 1, heapPkg::errNone);
    addHeldRow(heapPkg::actDec, 2, 0, 'h000, heapPkg::errNone);
    addHeldRow(heapPkg::actDec, 2, 0, 'h000, heapPkg::errEmpty);
    // Reset action clears the bookkeeping
    addHeldRow(heapPkg::actReset, 0, 0, 'h000, heapPkg::errNone);
    addHeldRow(heapPkg::actSize, 0, 0, 'h000, heapPkg::errNotAllocated);
    addRow(heapPkg::actAlloc, 0, 0, 'h000, 0, heapPkg::errNone);
  endtask

  // Turns hold flags into concrete expected data
  task automatic resolveExpected();
    logic [`HEAP_DATA_BITS-1:0] last;
    last = '0;                                        // Data register after reset
    foreach (steps[i]) begin
      if (!steps[i].hold) last = steps[i].expData;
      wantData.push_back(last);
    end
  endtask

  //--------------------------------------------------
  // Checks
  //--------------------------------------------------
  task automatic checkRow(input int n);
    checks = checks + 3;
    assert (done === 1'b1) else begin
      errors++;
      $display("[FAIL] %0t row %0d: done not raised one cycle after strobe", $time, n);
    end
    assert (response.error === steps[n].expError) else begin
      errors++;
      $display("[FAIL] %0t row %0d: error %s, expected %s", $time, n,
               response.error.name(), steps[n].expError.name());
    end
    assert (response.data === wantData[n]) else begin
      errors++;
      $display("[FAIL] %0t row %0d: data 0x%03h, expected 0x%03h", $time, n,
               response.data, wantData[n]);
    end
  endtask

  task automatic checkResetState();
    checks++;
    assert (done === 1'b0 && response.data === '0 && response.error === heapPkg::errNone)
    else begin
      errors++;
      $display("[FAIL] %0t outputs not cleared by reset", $time);
    end
  endtask

  task automatic checkDoneLow();
    checks++;
    assert (done === 1'b0) else begin
      errors++;
      $display("[FAIL] %0t done still high with no strobe", $time);
    end
  endtask

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------
  initial begin : main
    resetN     = 1'b0;
    strobe     = 1'b0;
    request    = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    buildTable();
    resolveExpected();
    cycleLimit = steps.size() + ResetCycles + 20;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    checkResetState();
    foreach (steps[n]) begin
      request.action = steps[n].action;               // One request per cycle
      request.array  = steps[n].array;
      request.index  = steps[n].index;
      request.data   = steps[n].data;
      strobe         = 1'b1;
      @(negedge clock);
      checkRow(n);
    end
    strobe = 1'b0;
    @(negedge clock);
    checkDoneLow();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/heapPkg.sv
verilog/arrayAllocator.sv
verilog/elementStore.sv
verilog/responseMerge.sv
verilog/heapMemory.sv
verification/heapMemory_assertions.sv
verification/heapMemoryTb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the heap testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= heapMemoryTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_TEXT ?= ALL CHECKS PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) \
	  -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR)
